/* bench/lsu_tb.sv */
`timescale 1ns/100ps
`include "lsu_defines.svh"

module lsu_tb;

    localparam int          TIMEOUT   = 50;
    localparam logic [31:0] MEM_BYTES = `SRAM_WORDS * 4;

    // funct3 codes of the RV32I loads and stores
    localparam logic [2:0] F_B  = 3'b000;
    localparam logic [2:0] F_H  = 3'b001;
    localparam logic [2:0] F_W  = 3'b010;
    localparam logic [2:0] F_BU = 3'b100;
    localparam logic [2:0] F_HU = 3'b101;

    logic        clk;
    logic        rst;
    logic        start;
    logic [31:0] inst;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic        busy;
    logic        done;
    logic        fault;
    logic        rd_wen;
    logic [4:0]  rd_idx;
    logic [31:0] rd_data;

    // byte-wide copy of the SRAM
    logic [7:0]  ref_mem [0:`SRAM_WORDS*4-1];
    int          seed;

    // outputs captured at done
    logic        got_fault;
    logic        got_wen;
    logic [4:0]  got_idx;
    logic [31:0] got_data;
    int          got_cycles;

    lsu_top i_lsu_top (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .inst    (inst),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .busy    (busy),
        .done    (done),
        .fault   (fault),
        .rd_wen  (rd_wen),
        .rd_idx  (rd_idx),
        .rd_data (rd_data)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // natural alignment, access size in bytes is 1 << funct3[1:0]
    function automatic logic misaligned(input logic [2:0] funct3, input logic [31:0] addr);
        int nbytes;
        nbytes = 1 << funct3[1:0];
        return (addr % nbytes) != 0;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]} ^ 32'hc3a5_0f96;
    endfunction

    // expected load value, extended by the RISC-V rule
    function automatic logic [31:0] ref_load(input logic [2:0] funct3, input logic [31:0] addr);
        logic [31:0] a;
        logic [31:0] value;
        a = addr % MEM_BYTES;
        case (funct3[1:0])
            2'b00: begin
                value = {24'h0, ref_mem[a]};
                if (!funct3[2] && value[7])
                    value[31:8] = '1;
            end
            2'b01: begin
                value = {16'h0, ref_mem[a + 1], ref_mem[a]};
                if (!funct3[2] && value[15])
                    value[31:16] = '1;
            end
            default: value = {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
        endcase
        return value;
    endfunction

    function automatic void ref_store(input logic [2:0] funct3, input logic [31:0] addr,
                                      input logic [31:0] data);
        logic [31:0] a;
        int          count;
        a     = addr % MEM_BYTES;
        count = (funct3[1:0] == 2'b00) ? 1 : (funct3[1:0] == 2'b01) ? 2 : 4;
        for (int k = 0; k < count; k++)
            ref_mem[a + 32'(k)] = data[8*k +: 8];
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // one start pulse, then wait for done
    task automatic issue_and_wait(input logic [31:0] word, input logic [31:0] a,
                                  input logic [31:0] b);
        int cycles;
        @(posedge clk);
        inst    <= word;
        rs1_val <= a;
        rs2_val <= b;
        start   <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check("busy", 32'(busy), 32'd1);
        cycles = 0;
        while (!done && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            $display("done never arrived within %0d cycles at %0t ns", TIMEOUT, $time);
            $display("Finished with errors");
            $fatal(1, "timeout waiting for done");
        end else begin
            got_fault  = fault;
            got_wen    = rd_wen;
            got_idx    = rd_idx;
            got_data   = rd_data;
            got_cycles = cycles;
            check("busy", 32'(busy), 32'd0);
        end
    endtask

    task automatic do_load(input logic [2:0] funct3, input logic [4:0] rd,
                           input logic [31:0] base, input logic [11:0] imm);
        logic [31:0] addr;
        logic        exp_fault;
        addr      = base + sext12(imm);
        exp_fault = misaligned(funct3, addr);
        issue_and_wait({imm, 5'd1, funct3, rd, 7'b0000011}, base, 32'h0);
        check("fault", 32'(got_fault), 32'(exp_fault));
        check("rd_wen", 32'(got_wen), 32'(!exp_fault));
        check("rd_idx", 32'(got_idx), 32'(rd));
        check("rd_data", got_data, exp_fault ? 32'h0 : ref_load(funct3, addr));
        if (exp_fault)
            check("fault latency", 32'(got_cycles), 32'd2);
    endtask

    task automatic do_store(input logic [2:0] funct3, input logic [31:0] base,
                            input logic [11:0] imm, input logic [31:0] data);
        logic [31:0] addr;
        logic        exp_fault;
        addr      = base + sext12(imm);
        exp_fault = misaligned(funct3, addr);
        issue_and_wait({imm[11:5], 5'd2, 5'd1, funct3, imm[4:0], 7'b0100011}, base, data);
        check("fault", 32'(got_fault), 32'(exp_fault));
        check("rd_wen", 32'(got_wen), 32'd0);
        check("rd_data", got_data, 32'h0);
        if (exp_fault)
            check("fault latency", 32'(got_cycles), 32'd2);
        else
            ref_store(funct3, addr, data);
    endtask

    task automatic do_illegal(input logic [31:0] word);
        issue_and_wait(word, 32'h40, 32'h0);
        check("fault", 32'(got_fault), 32'd1);
        check("rd_wen", 32'(got_wen), 32'd0);
        check("rd_data", got_data, 32'h0);
        check("fault latency", 32'(got_cycles), 32'd2);
    endtask

    task automatic load_expect(input logic [2:0] funct3, input logic [31:0] addr,
                               input logic [31:0] expected);
        do_load(funct3, 5'd3, addr, 12'h000);
        check("rd_data", got_data, expected);
    endtask

    // known contents in the first 64 words
    task automatic fill_memory();
        for (int k = 0; k < 64; k++)
            do_store(F_W, 32'(4 * k), 12'h000, fill_word(32'(4 * k)));
    endtask

    task automatic test_word_access();
        logic [31:0] base [0:4];
        logic [11:0] imm [0:4];
        base[0] = 32'h0000_0100;
        imm[0]  = 12'h000;
        base[1] = 32'h0000_0200;
        imm[1]  = 12'h024;
        base[2] = 32'h0000_0340;
        imm[2]  = 12'hff0;
        base[3] = 32'h0000_1000;
        imm[3]  = 12'h7fc;
        // lands past the SRAM and wraps to word 3
        base[4] = 32'h0000_2010;
        imm[4]  = 12'hffc;
        for (int k = 0; k < 5; k++)
            do_store(F_W, base[k], imm[k], 32'h1357_9bdf + 32'(k) * 32'h1111_0101);
        for (int k = 0; k < 5; k++) begin
            do_load(F_W, 5'(5 + k), base[k], imm[k]);
            do_load(F_W, 5'(20 + k), (base[k] + sext12(imm[k])) % MEM_BYTES, 12'h000);
        end
    endtask

    task automatic test_lanes();
        for (int k = 0; k < 4; k++) begin
            do_store(F_B, 32'h40, 12'(k), 32'h5a5a_5a00 + 32'(17 * k + 3));
            do_load(F_W, 5'd10, 32'h40, 12'h000);
        end
        do_store(F_H, 32'h44, 12'h000, 32'hdead_8421);
        do_load(F_W, 5'd11, 32'h44, 12'h000);
        do_store(F_H, 32'h44, 12'h002, 32'hbeef_7e3c);
        do_load(F_W, 5'd12, 32'h44, 12'h000);
    endtask

    task automatic test_extension();
        do_store(F_B, 32'h60, 12'h000, 32'h0000_0080);
        do_store(F_B, 32'h60, 12'h001, 32'h0000_007f);
        do_store(F_H, 32'h64, 12'h000, 32'h0000_8001);
        do_store(F_H, 32'h64, 12'h002, 32'h0000_7ffe);
        load_expect(F_B, 32'h60, 32'hffff_ff80);
        load_expect(F_BU, 32'h60, 32'h0000_0080);
        load_expect(F_B, 32'h61, 32'h0000_007f);
        load_expect(F_BU, 32'h61, 32'h0000_007f);
        load_expect(F_H, 32'h64, 32'hffff_8001);
        load_expect(F_HU, 32'h64, 32'h0000_8001);
        load_expect(F_H, 32'h66, 32'h0000_7ffe);
        load_expect(F_HU, 32'h66, 32'h0000_7ffe);
    endtask

    task automatic test_faults();
        do_load(F_H, 5'd7, 32'h80, 12'h001);
        do_load(F_W, 5'd8, 32'h80, 12'h002);
        do_store(F_W, 32'h84, 12'h001, 32'hffff_ffff);
        // the store above must have left the word alone
        do_load(F_W, 5'd9, 32'h84, 12'h000);
        // addi and add are not memory opcodes
        do_illegal(32'h0010_0093);
        do_illegal(32'h0020_8133);
    endtask

    task automatic test_random();
        logic [31:0] r;
        logic [31:0] data;
        logic [31:0] addr;
        logic [11:0] imm;
        logic [2:0]  funct3;
        for (int n = 0; n < 200; n++) begin
            r    = $random(seed);
            data = $random(seed);
            imm  = {{4{r[19]}}, r[19:12]};
            case (r[2:1])
                2'b00: begin
                    funct3 = {r[3], 2'b00};
                    addr   = {24'h0, r[9:4], r[11:10]};
                end
                2'b01: begin
                    funct3 = {r[3], 2'b01};
                    addr   = {24'h0, r[9:4], r[11], 1'b0};
                end
                default: begin
                    funct3 = F_W;
                    addr   = {24'h0, r[9:4], 2'b00};
                end
            endcase
            if (r[0])
                do_store({1'b0, funct3[1:0]}, addr - sext12(imm), imm, data);
            else
                do_load(funct3, r[28:24], addr - sext12(imm), imm);
        end
    endtask

    initial begin
        seed    = 32'h2b7e422d;
        clk     = 1'b0;
        rst     <= 1'b1;
        start   <= 1'b0;
        inst    <= 32'h0;
        rs1_val <= 32'h0;
        rs2_val <= 32'h0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        fill_memory();
        test_word_access();
        test_lanes();
        test_extension();
        test_faults();
        test_random();
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* list.f */
+incdir+verilog
verilog/lsu_pkg.sv
verilog/mem_bus_if.sv
verilog/lsu_decode.sv
verilog/lsu_execute.sv
verilog/lsu_result.sv
verilog/data_sram.sv
verilog/lsu_top.sv
bench/lsu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the load/store unit testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module lsu_tb -f list.f -o lsu_sim
status=$?
if [ $status -ne 0 ]; then
    echo "run.sh: Verilator build failed with status $status"
    exit 1
fi

./obj_dir/lsu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "run.sh: simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
    echo "run.sh: PASS"
    exit 0
else
    echo "run.sh: FAIL, pass message not found in $LOG"
    exit 1
fi

/* verilog/data_sram.sv */
`timescale 1ns/100ps
`include "lsu_defines.svh"

module data_sram (
    input logic      clk,
    input logic      rst,
    mem_bus_if.slave bus
);

    localparam int IDX_W = $clog2(`SRAM_WORDS);
    localparam int CNT_W = $clog2(`SRAM_LATENCY + 1);

    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_RLAT  = 3'd1;
    localparam logic [2:0] S_RDATA = 3'd2;
    localparam logic [2:0] S_WDATA = 3'd3;
    localparam logic [2:0] S_BRESP = 3'd4;

    logic [`LSU_XLEN-1:0] mem [0:`SRAM_WORDS-1];
    logic [2:0]           state;
    logic [IDX_W-1:0]     idx;
    logic [CNT_W-1:0]     count;
    logic                 w_fire;
    logic                 r_load;

    assign w_fire = (state == S_WDATA) && bus.wvalid && bus.wready;
    assign r_load = (state == S_RLAT) && (count == CNT_W'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= S_IDLE;
            count       <= '0;
            bus.arready <= 1'b0;
            bus.awready <= 1'b0;
            bus.wready  <= 1'b0;
            bus.rvalid  <= 1'b0;
            bus.bvalid  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    bus.arready <= 1'b1;
                    bus.awready <= 1'b1;
                    if (bus.arvalid && bus.arready) begin
                        bus.arready <= 1'b0;
                        bus.awready <= 1'b0;
                        count       <= CNT_W'(`SRAM_LATENCY - 1);
                        state       <= S_RLAT;
                    end else if (bus.awvalid && bus.awready) begin
                        bus.arready <= 1'b0;
                        bus.awready <= 1'b0;
                        bus.wready  <= 1'b1;
                        state       <= S_WDATA;
                    end
                end
                S_RLAT: begin
                    if (r_load) begin
                        bus.rvalid <= 1'b1;
                        state      <= S_RDATA;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                S_RDATA: begin
                    // held until the master takes it
                    if (bus.rready) begin
                        bus.rvalid <= 1'b0;
                        state      <= S_IDLE;
                    end
                end
                S_WDATA: begin
                    if (w_fire) begin
                        bus.wready <= 1'b0;
                        bus.bvalid <= 1'b1;
                        state      <= S_BRESP;
                    end
                end
                S_BRESP: begin
                    if (bus.bready) begin
                        bus.bvalid <= 1'b0;
                        state      <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // word index latched from whichever address channel fired
    always_ff @(posedge clk) begin
        if (state == S_IDLE && bus.arvalid && bus.arready) begin
            idx <= bus.araddr[IDX_W+1:2];
        end else if (state == S_IDLE && bus.awvalid && bus.awready) begin
            idx <= bus.awaddr[IDX_W+1:2];
        end
    end

    always_ff @(posedge clk) begin
        if (r_load) begin
            bus.rdata <= mem[idx];
        end
        for (int lane = 0; lane < `LSU_XLEN/8; lane++) begin
            if (w_fire && bus.wstrb[lane]) begin
                mem[idx][8*lane +: 8] <= bus.wdata[8*lane +: 8];
            end
        end
    end

    // execute must never issue an empty write
    a_wstrb_nonzero: assert property (
        @(posedge clk) disable iff (rst) w_fire |-> bus.wstrb != '0
    );

endmodule

/* verilog/lsu_decode.sv */
`timescale 1ns/100ps
`include "lsu_defines.svh"

module lsu_decode (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  lsu_pkg::inst_u       inst,
    input  logic [`LSU_XLEN-1:0] rs1_val,
    input  logic [`LSU_XLEN-1:0] rs2_val,
    output logic                 req_valid,
    output lsu_pkg::mem_req_t    req,
    output logic                 fault
);

    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    logic                 is_load;
    logic                 is_store;
    logic [11:0]          imm12;
    logic [`LSU_XLEN-1:0] addr;
    logic                 bad_funct3;
    logic                 misaligned;
    logic                 bad;

    assign is_load  = inst.i.opcode == OP_LOAD;
    assign is_store = inst.s.opcode == OP_STORE;

    // stores split the immediate around rs2
    assign imm12 = is_store ? {inst.s.imm_hi, inst.s.imm_lo} : inst.i.imm;
    assign addr  = rs1_val + {{(`LSU_XLEN-12){imm12[11]}}, imm12};

    // loads allow 000,001,010,100,101; stores only 000..010
    assign bad_funct3 = (inst.i.funct3[1:0] == 2'b11) ||
                        (is_load && inst.i.funct3[2] && inst.i.funct3[1]) ||
                        (is_store && inst.i.funct3[2]);

    assign misaligned = (inst.i.funct3[1:0] == 2'b01 && addr[0]) ||
                        (inst.i.funct3[1:0] == 2'b10 && addr[1:0] != 2'b00);

    assign bad = !(is_load || is_store) || bad_funct3 || misaligned;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid <= 1'b0;
            fault     <= 1'b0;
        end else begin
            req_valid <= start;
            fault     <= start && bad;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req.is_store <= is_store;
            req.size     <= lsu_pkg::access_size_e'(inst.i.funct3[1:0]);
            req.sign     <= !inst.i.funct3[2];
            req.addr     <= addr;
            req.wdata    <= rs2_val;
            req.rd       <= inst.i.rd;
        end
    end

    // a new start must wait until execute has taken the request
    a_no_start_on_pending: assert property (
        @(posedge clk) disable iff (rst) req_valid |-> !start
    );

endmodule

/* verilog/lsu_defines.svh */
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// data and address width of the core
`define LSU_XLEN 32

// data SRAM depth in words
// addresses wrap modulo this depth
`define SRAM_WORDS 1024

// cycles from read-address handshake to read data valid
// the SRAM counter needs a value of 2 or more
`define SRAM_LATENCY 2

`endif

/* verilog/lsu_execute.sv */
`timescale 1ns/100ps
`include "lsu_defines.svh"

module lsu_execute (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    input  lsu_pkg::mem_req_t  req,
    input  logic               fault,
    mem_bus_if.master          bus,
    output logic               busy,
    output logic               rsp_valid,
    output lsu_pkg::load_rsp_t rsp
);

    localparam logic [2:0] ST_IDLE   = 3'd0;
    localparam logic [2:0] ST_AR     = 3'd1;
    localparam logic [2:0] ST_R      = 3'd2;
    localparam logic [2:0] ST_AW     = 3'd3;
    localparam logic [2:0] ST_W      = 3'd4;
    localparam logic [2:0] ST_B      = 3'd5;
    localparam logic [2:0] ST_FINISH = 3'd6;

    logic [2:0]           state;
    logic [3:0]           strb;
    logic [`LSU_XLEN-1:0] lane_data;
    logic                 accept;

    assign accept = (state == ST_IDLE) && req_valid;

    // byte lanes touched by the store
    always_comb begin
        case (req.size)
            lsu_pkg::SZ_BYTE: strb = 4'b0001 << req.addr[1:0];
            lsu_pkg::SZ_HALF: strb = req.addr[1] ? 4'b1100 : 4'b0011;
            default:          strb = 4'b1111;
        endcase
    end

    assign lane_data = req.wdata << {req.addr[1:0], 3'b000};

    // covers the pending request until result raises done
    assign busy = req_valid || (state != ST_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            rsp_valid   <= 1'b0;
            bus.arvalid <= 1'b0;
            bus.rready  <= 1'b0;
            bus.awvalid <= 1'b0;
            bus.wvalid  <= 1'b0;
            bus.bready  <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req_valid) begin
                        // faults complete without touching the bus
                        if (fault) begin
                            rsp_valid <= 1'b1;
                            state     <= ST_FINISH;
                        end else if (req.is_store) begin
                            bus.awvalid <= 1'b1;
                            state       <= ST_AW;
                        end else begin
                            bus.arvalid <= 1'b1;
                            state       <= ST_AR;
                        end
                    end
                end
                ST_AR: begin
                    if (bus.arready) begin
                        bus.arvalid <= 1'b0;
                        bus.rready  <= 1'b1;
                        state       <= ST_R;
                    end
                end
                ST_R: begin
                    if (bus.rvalid) begin
                        bus.rready <= 1'b0;
                        rsp_valid  <= 1'b1;
                        state      <= ST_FINISH;
                    end
                end
                ST_AW: begin
                    if (bus.awready) begin
                        bus.awvalid <= 1'b0;
                        bus.wvalid  <= 1'b1;
                        state       <= ST_W;
                    end
                end
                ST_W: begin
                    if (bus.wready) begin
                        bus.wvalid <= 1'b0;
                        state      <= ST_B;
                    end
                end
                ST_B: begin
                    // bready follows bvalid by one cycle
                    if (bus.bvalid && bus.bready) begin
                        bus.bready <= 1'b0;
                        rsp_valid  <= 1'b1;
                        state      <= ST_FINISH;
                    end else if (bus.bvalid) begin
                        bus.bready <= 1'b1;
                    end
                end
                ST_FINISH: state <= ST_IDLE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            bus.araddr   <= req.addr;
            bus.awaddr   <= req.addr;
            bus.wdata    <= lane_data;
            bus.wstrb    <= strb;
            rsp.is_store <= req.is_store;
            rsp.fault    <= fault;
            rsp.raw      <= '0;
            rsp.offset   <= req.addr[1:0];
            rsp.size     <= req.size;
            rsp.sign     <= req.sign;
            rsp.rd       <= req.rd;
        end else if (state == ST_R && bus.rvalid && bus.rready) begin
            rsp.raw <= bus.rdata;
        end
    end

    // only one access is ever in flight
    a_single_addr_channel: assert property (
        @(posedge clk) disable iff (rst) !(bus.arvalid && bus.awvalid)
    );

endmodule

/* verilog/lsu_pkg.sv */
`include "lsu_defines.svh"

package lsu_pkg;

    // I-format view, used by loads
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // S-format view, used by stores
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // one instruction word seen through either format
    typedef union packed {
        i_fmt_t i;
        s_fmt_t s;
    } inst_u;

    // encoding follows funct3[1:0]
    typedef enum logic [1:0] {
        SZ_BYTE = 2'b00,
        SZ_HALF = 2'b01,
        SZ_WORD = 2'b10
    } access_size_e;

    // decoded request from decode to execute
    typedef struct packed {
        logic                 is_store;
        access_size_e         size;
        logic                 sign;
        logic [`LSU_XLEN-1:0] addr;
        logic [`LSU_XLEN-1:0] wdata;
        logic [4:0]           rd;
    } mem_req_t;

    // completion record from execute to result
    typedef struct packed {
        logic                 is_store;
        logic                 fault;
        logic [`LSU_XLEN-1:0] raw;
        logic [1:0]           offset;
        access_size_e         size;
        logic                 sign;
        logic [4:0]           rd;
    } load_rsp_t;

endpackage

/* verilog/lsu_result.sv */
`timescale 1ns/100ps
`include "lsu_defines.svh"

module lsu_result (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rsp_valid,
    input  lsu_pkg::load_rsp_t   rsp,
    output logic                 done,
    output logic                 fault,
    output logic                 rd_wen,
    output logic [4:0]           rd_idx,
    output logic [`LSU_XLEN-1:0] rd_data
);

    logic [`LSU_XLEN-1:0] shifted;
    logic [`LSU_XLEN-1:0] extended;

    // bring the addressed lane down to bit 0
    assign shifted = rsp.raw >> {rsp.offset, 3'b000};

    always_comb begin
        case (rsp.size)
            lsu_pkg::SZ_BYTE:
                extended = {{(`LSU_XLEN-8){rsp.sign && shifted[7]}}, shifted[7:0]};
            lsu_pkg::SZ_HALF:
                extended = {{(`LSU_XLEN-16){rsp.sign && shifted[15]}}, shifted[15:0]};
            default:
                extended = shifted;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done   <= 1'b0;
            fault  <= 1'b0;
            rd_wen <= 1'b0;
        end else begin
            done   <= rsp_valid;
            fault  <= rsp_valid && rsp.fault;
            rd_wen <= rsp_valid && !rsp.is_store && !rsp.fault;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_valid) begin
            rd_idx  <= rsp.rd;
            // nothing to write back for stores and faults
            rd_data <= (rsp.is_store || rsp.fault) ? '0 : extended;
        end
    end

endmodule

/* verilog/lsu_top.sv */
`timescale 1ns/100ps
`include "lsu_defines.svh"

module lsu_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic [31:0]          inst,
    input  logic [`LSU_XLEN-1:0] rs1_val,
    input  logic [`LSU_XLEN-1:0] rs2_val,
    output logic                 busy,
    output logic                 done,
    output logic                 fault,
    output logic                 rd_wen,
    output logic [4:0]           rd_idx,
    output logic [`LSU_XLEN-1:0] rd_data
);

    logic               req_valid;
    logic               req_fault;
    lsu_pkg::mem_req_t  req;
    logic               rsp_valid;
    lsu_pkg::load_rsp_t rsp;

    mem_bus_if bus_if ();

    lsu_decode i_lsu_decode (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .inst      (inst),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .req_valid (req_valid),
        .req       (req),
        .fault     (req_fault)
    );

    lsu_execute i_lsu_execute (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .fault     (req_fault),
        .bus       (bus_if.master),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    lsu_result i_lsu_result (
        .clk       (clk),
        .rst       (rst),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .done      (done),
        .fault     (fault),
        .rd_wen    (rd_wen),
        .rd_idx    (rd_idx),
        .rd_data   (rd_data)
    );

    data_sram i_data_sram (
        .clk (clk),
        .rst (rst),
        .bus (bus_if.slave)
    );

endmodule

/* verilog/mem_bus_if.sv */
`timescale 1ns/100ps
`include "lsu_defines.svh"

interface mem_bus_if;

    // read address channel
    logic [`LSU_XLEN-1:0]   araddr;
    logic                   arvalid;
    logic                   arready;

    // read data channel
    logic [`LSU_XLEN-1:0]   rdata;
    logic                   rvalid;
    logic                   rready;

    // write address channel
    logic [`LSU_XLEN-1:0]   awaddr;
    logic                   awvalid;
    logic                   awready;

    // write data channel, one strobe bit per byte lane
    logic [`LSU_XLEN-1:0]   wdata;
    logic [`LSU_XLEN/8-1:0] wstrb;
    logic                   wvalid;
    logic                   wready;

    // write response, no status since the SRAM never fails
    logic                   bvalid;
    logic                   bready;

    modport master (
        output araddr, arvalid, rready,
        output awaddr, awvalid, wdata, wstrb, wvalid, bready,
        input  arready, rdata, rvalid, awready, wready, bvalid
    );

    modport slave (
        input  araddr, arvalid, rready,
        input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
        output arready, rdata, rvalid, awready, wready, bvalid
    );

endinterface
